// ==== hw/chip8_config.svh ====
//################################################
// Build-time constants of the CHIP-8 control core
// Included by the core package and by RTL that needs sizes or rates
//################################################
`ifndef CHIP8_CONFIG_SVH
`define CHIP8_CONFIG_SVH

// Clock cycles per fetch step, at least 4
`define CHIP8_STEP_CYCLES 8

// Clock cycles per timer tick
`define CHIP8_TICK_DIV 16

// Program counter after reset, start of program space
`define CHIP8_PC_RESET 12'h200

// 4 KiB program memory
`define CHIP8_MEM_AW 12

// 64 x 32 display
`define CHIP8_DISP_XW 6
`define CHIP8_DISP_YW 5

`endif

// ==== hw/chip8_core_pkg.sv ====
//################################################
// Machine types of the CHIP-8 core
// Data widths, emulator state and fetch step counter
//################################################
`include "chip8_config.svh"

package chip8_core_pkg;

    // Memory byte or V register
    typedef logic [7:0] byte_t;

    typedef logic [`CHIP8_MEM_AW-1:0] mem_addr_t;

    // V0 to VF
    typedef logic [3:0] reg_idx_t;

    typedef logic [15:0] index_t;

    // High byte from pc, low byte from pc+1
    typedef logic [15:0] instr_t;

    typedef logic [`CHIP8_DISP_XW-1:0] pix_x_t;
    typedef logic [`CHIP8_DISP_YW-1:0] pix_y_t;

    // Cycle position inside one fetch step
    typedef logic [15:0] step_t;

    // Codes match the host state register
    typedef enum logic [1:0] {
        st_running      = 2'd0,
        st_loading_rom  = 2'd1,
        st_loading_font = 2'd2,
        st_paused       = 2'd3
    } emu_state_t;

endpackage

// ==== hw/chip8_bus_pkg.sv ====
//################################################
// Host bus types of the CHIP-8 core
// Address map, access targets and the decoded request
//################################################
package chip8_bus_pkg;

    typedef logic [17:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;

    // Register address map, memory when the select bit is set
    localparam int unsigned mem_sel_bit    = 16;
    localparam bus_addr_t   addr_vreg_last = 18'h0f;
    localparam bus_addr_t   addr_index     = 18'h10;
    localparam bus_addr_t   addr_sound     = 18'h11;
    localparam bus_addr_t   addr_delay     = 18'h12;
    localparam bus_addr_t   addr_pc        = 18'h14;
    localparam bus_addr_t   addr_state     = 18'h16;
    localparam bus_addr_t   addr_pixel     = 18'h17;
    localparam bus_addr_t   addr_instr     = 18'h18;

    // Pixel fields inside writedata
    localparam int unsigned pix_x_lsb   = 8;
    localparam int unsigned pix_y_lsb   = 0;
    localparam int unsigned pix_val_bit = 16;

    typedef enum logic [3:0] {
        tgt_mem,
        tgt_vreg,
        tgt_index,
        tgt_sound,
        tgt_delay,
        tgt_pc,
        tgt_state,
        tgt_pixel,
        tgt_instr,
        tgt_none
    } bus_target_t;

    typedef struct packed {
        logic                      valid;
        logic                      write;
        bus_target_t               target;
        chip8_core_pkg::mem_addr_t mem_addr;
        chip8_core_pkg::reg_idx_t  reg_idx;
        chip8_core_pkg::pix_x_t    pix_x;
        chip8_core_pkg::pix_y_t    pix_y;
        bus_data_t                 wdata;
    } host_req_t;

    // True when the request writes the given target
    function automatic logic req_writes(host_req_t r, bus_target_t t);
        return r.valid && r.write && (r.target == t);
    endfunction

endpackage

// ==== hw/host_decoder.sv ====
//################################################
// Host bus input stage
// Samples each chipselect cycle and decodes it into a request
//################################################
`timescale 1ns/1ps

module host_decoder (
    input  logic                      clk,
    input  logic                      cpu_fbreset,
    input  logic                      chipselect,
    input  logic                      write,
    input  chip8_bus_pkg::bus_addr_t  address,
    input  chip8_bus_pkg::bus_data_t  writedata,
    output chip8_bus_pkg::host_req_t  req
);
    import chip8_core_pkg::*;
    import chip8_bus_pkg::*;

    // Raw bus sample
    logic        cs_q;
    logic        wr_q;
    bus_addr_t   addr_q;
    bus_data_t   wdata_q;

    bus_target_t tgt;
    host_req_t   req_d;

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            cs_q <= 1'b0;
        end else begin
            cs_q <= chipselect;
        end
    end

    always_ff @(posedge clk) begin
        wr_q    <= write;
        addr_q  <= address;
        wdata_q <= writedata;
    end

    always_comb begin
        if (addr_q[mem_sel_bit]) begin
            tgt = tgt_mem;
        end else if (addr_q <= addr_vreg_last) begin
            tgt = tgt_vreg;
        end else begin
            case (addr_q)
                addr_index: tgt = tgt_index;
                addr_sound: tgt = tgt_sound;
                addr_delay: tgt = tgt_delay;
                addr_pc:    tgt = tgt_pc;
                addr_state: tgt = tgt_state;
                addr_pixel: tgt = tgt_pixel;
                addr_instr: tgt = tgt_instr;
                default:    tgt = tgt_none;
            endcase
        end
    end

    // Pixel coordinates ride in writedata for reads too
    always_comb begin
        req_d.valid    = cs_q;
        req_d.write    = wr_q;
        req_d.target   = tgt;
        req_d.mem_addr = addr_q[$bits(mem_addr_t)-1:0];
        req_d.reg_idx  = addr_q[$bits(reg_idx_t)-1:0];
        req_d.pix_x    = wdata_q[pix_x_lsb +: $bits(pix_x_t)];
        req_d.pix_y    = wdata_q[pix_y_lsb +: $bits(pix_y_t)];
        req_d.wdata    = wdata_q;
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            req <= '0;
        end else begin
            req <= req_d;
        end
    end

endmodule

// ==== hw/chip8_storage.sv ====
//################################################
// Program memory, V registers, I register and pixel buffer
// Reads are registered, host writes land one cycle after the request
//################################################
`timescale 1ns/1ps
`include "chip8_config.svh"

module chip8_storage (
    input  logic                      clk,
    input  logic                      cpu_fbreset,
    input  chip8_bus_pkg::host_req_t  req,
    input  logic                      fetch_en,
    input  chip8_core_pkg::mem_addr_t fetch_addr_a,
    input  chip8_core_pkg::mem_addr_t fetch_addr_b,
    output chip8_core_pkg::byte_t     mem_q_a,
    output chip8_core_pkg::byte_t     mem_q_b,
    output chip8_core_pkg::byte_t     vreg_q,
    output chip8_core_pkg::index_t    index_q,
    output logic                      pixel_q
);
    import chip8_core_pkg::*;
    import chip8_bus_pkg::*;

    localparam int unsigned mem_depth  = 1 << `CHIP8_MEM_AW;
    localparam int unsigned vreg_depth = 1 << $bits(reg_idx_t);
    localparam int unsigned pix_aw     = `CHIP8_DISP_XW + `CHIP8_DISP_YW;
    localparam int unsigned pix_depth  = 1 << pix_aw;

    byte_t     prog_mem [mem_depth];
    byte_t     vregs    [vreg_depth];
    logic      pix_mem  [pix_depth];

    mem_addr_t         addr_a;
    logic [pix_aw-1:0] pix_addr;

    // Fetch borrows port A only on cycles without a request
    assign addr_a   = fetch_en ? fetch_addr_a : req.mem_addr;
    assign pix_addr = {req.pix_y, req.pix_x};

    // Port A, host read/write or fetch of the high byte
    always_ff @(posedge clk) begin
        if (req_writes(req, tgt_mem)) begin
            prog_mem[addr_a] <= req.wdata[$bits(byte_t)-1:0];
        end
        mem_q_a <= prog_mem[addr_a];
    end

    // Port B, fetch of the low byte
    always_ff @(posedge clk) begin
        mem_q_b <= prog_mem[fetch_addr_b];
    end

    always_ff @(posedge clk) begin
        if (req_writes(req, tgt_vreg)) begin
            vregs[req.reg_idx] <= req.wdata[$bits(byte_t)-1:0];
        end
        vreg_q <= vregs[req.reg_idx];
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            index_q <= '0;
        end else if (req_writes(req, tgt_index)) begin
            index_q <= req.wdata[$bits(index_t)-1:0];
        end
    end

    // One bit per pixel, row-major by y
    always_ff @(posedge clk) begin
        if (req_writes(req, tgt_pixel)) begin
            pix_mem[pix_addr] <= req.wdata[pix_val_bit];
        end
        pixel_q <= pix_mem[pix_addr];
    end

endmodule

// ==== hw/fetch_sequencer.sv ====
//################################################
// Emulator state, program counter and instruction fetch
// One two-byte fetch per step while running, pc then moves by two
//################################################
`timescale 1ns/1ps
`include "chip8_config.svh"

module fetch_sequencer (
    input  logic                       clk,
    input  logic                       cpu_fbreset,
    input  chip8_bus_pkg::host_req_t   req,
    input  chip8_core_pkg::byte_t      mem_q_a,
    input  chip8_core_pkg::byte_t      mem_q_b,
    output logic                       fetch_en,
    output chip8_core_pkg::mem_addr_t  fetch_addr_a,
    output chip8_core_pkg::mem_addr_t  fetch_addr_b,
    output chip8_core_pkg::mem_addr_t  pc,
    output chip8_core_pkg::emu_state_t state,
    output chip8_core_pkg::instr_t     instr
);
    import chip8_core_pkg::*;
    import chip8_bus_pkg::*;

    localparam step_t last_step = step_t'(`CHIP8_STEP_CYCLES - 1);

    step_t      step;
    logic       fetch_pend;
    logic       state_wr;
    logic       pc_wr;
    logic       advance;
    emu_state_t new_state;

    assign new_state = emu_state_t'(req.wdata[1:0]);
    assign state_wr  = req_writes(req, tgt_state);
    assign pc_wr     = req_writes(req, tgt_pc);

    // Any host request stalls the step counter
    assign advance = (state == st_running) && !req.valid;

    assign fetch_en     = advance && (step == '0);
    assign fetch_addr_a = pc;
    assign fetch_addr_b = pc + mem_addr_t'(1);

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            state <= st_paused;
        end else if (state_wr) begin
            state <= new_state;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            pc   <= `CHIP8_PC_RESET;
            step <= '0;
        end else if (pc_wr) begin
            pc   <= req.wdata[$bits(mem_addr_t)-1:0];
            step <= '0;
        end else if (state_wr && (new_state == st_running)) begin
            step <= '0;
        end else if (advance) begin
            if (step == last_step) begin
                step <= '0;
                pc   <= pc + mem_addr_t'(2);
            end else begin
                step <= step + step_t'(1);
            end
        end
    end

    // Memory data is valid on the cycle right after the fetch address
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            fetch_pend <= 1'b0;
            instr      <= '0;
        end else begin
            fetch_pend <= fetch_en;
            if (fetch_pend) begin
                instr <= {mem_q_a, mem_q_b};
            end
        end
    end

endmodule

// ==== hw/timer_bank.sv ====
//################################################
// Sound and delay countdown timers
// Both count down once per divided tick, sound_on follows the sound timer
//################################################
`timescale 1ns/1ps
`include "chip8_config.svh"

module timer_bank (
    input  logic                     clk,
    input  logic                     cpu_fbreset,
    input  chip8_bus_pkg::host_req_t req,
    output chip8_core_pkg::byte_t    sound_val,
    output chip8_core_pkg::byte_t    delay_val,
    output logic                     sound_on
);
    import chip8_core_pkg::*;
    import chip8_bus_pkg::*;

    localparam int unsigned div_w    = $clog2(`CHIP8_TICK_DIV + 1);
    localparam int unsigned n_timers = 2;
    localparam logic [div_w-1:0] div_last = div_w'(`CHIP8_TICK_DIV - 1);

    // Slot 0 is sound, slot 1 is delay
    localparam bus_target_t timer_tgt [n_timers] = '{tgt_sound, tgt_delay};

    logic [div_w-1:0] div_cnt;
    logic             tick;
    byte_t            timers [n_timers];

    assign tick = (div_cnt == div_last);

    // Free running divider
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Host load wins over the tick
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            for (int i = 0; i < n_timers; i++) begin
                timers[i] <= '0;
            end
        end else begin
            for (int i = 0; i < n_timers; i++) begin
                if (req_writes(req, timer_tgt[i])) begin
                    timers[i] <= req.wdata[$bits(byte_t)-1:0];
                end else if (tick && (timers[i] != '0)) begin
                    timers[i] <= timers[i] - byte_t'(1);
                end
            end
        end
    end

    assign sound_val = timers[0];
    assign delay_val = timers[1];
    assign sound_on  = (timers[0] != '0);

endmodule

// ==== hw/readback_mux.sv ====
//################################################
// Host read path
// Lines the read target up with storage data and registers data_out
//################################################
`timescale 1ns/1ps

module readback_mux (
    input  logic                       clk,
    input  logic                       cpu_fbreset,
    input  chip8_bus_pkg::host_req_t   req,
    input  chip8_core_pkg::byte_t      mem_q_a,
    input  chip8_core_pkg::byte_t      vreg_q,
    input  chip8_core_pkg::index_t     index_q,
    input  logic                       pixel_q,
    input  chip8_core_pkg::byte_t      sound_val,
    input  chip8_core_pkg::byte_t      delay_val,
    input  chip8_core_pkg::mem_addr_t  pc,
    input  chip8_core_pkg::emu_state_t state,
    input  chip8_core_pkg::instr_t     instr,
    output chip8_bus_pkg::bus_data_t   data_out
);
    import chip8_bus_pkg::*;

    logic        rd_valid;
    bus_target_t rd_tgt;
    bus_data_t   rd_val;

    // Same stage as the storage read registers
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            rd_valid <= 1'b0;
            rd_tgt   <= tgt_none;
        end else begin
            rd_valid <= req.valid && !req.write;
            rd_tgt   <= req.target;
        end
    end

    always_comb begin
        case (rd_tgt)
            tgt_mem:   rd_val = bus_data_t'(mem_q_a);
            tgt_vreg:  rd_val = bus_data_t'(vreg_q);
            tgt_index: rd_val = bus_data_t'(index_q);
            tgt_sound: rd_val = bus_data_t'(sound_val);
            tgt_delay: rd_val = bus_data_t'(delay_val);
            tgt_pc:    rd_val = bus_data_t'(pc);
            tgt_state: rd_val = bus_data_t'(state);
            tgt_pixel: rd_val = bus_data_t'(pixel_q);
            tgt_instr: rd_val = bus_data_t'(instr);
            default:   rd_val = '0;
        endcase
    end

    // Holds the last read result across writes
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            data_out <= '0;
        end else if (rd_valid) begin
            data_out <= rd_val;
        end
    end

endmodule

// ==== hw/chip8_top.sv ====
//################################################
// Top level of the CHIP-8 control core
// Host register port in, read data and sound level out
//################################################
`timescale 1ns/1ps

module chip8_top (
    input  logic                     clk,
    input  logic                     cpu_fbreset,
    input  logic                     chipselect,
    input  logic                     write,
    input  chip8_bus_pkg::bus_addr_t address,
    input  chip8_bus_pkg::bus_data_t writedata,
    output chip8_bus_pkg::bus_data_t data_out,
    output logic                     sound_on
);
    chip8_bus_pkg::host_req_t   req;
    logic                       fetch_en;
    chip8_core_pkg::mem_addr_t  fetch_addr_a;
    chip8_core_pkg::mem_addr_t  fetch_addr_b;
    chip8_core_pkg::mem_addr_t  pc;
    chip8_core_pkg::emu_state_t state;
    chip8_core_pkg::instr_t     instr;
    chip8_core_pkg::byte_t      mem_q_a;
    chip8_core_pkg::byte_t      mem_q_b;
    chip8_core_pkg::byte_t      vreg_q;
    chip8_core_pkg::index_t     index_q;
    logic                       pixel_q;
    chip8_core_pkg::byte_t      sound_val;
    chip8_core_pkg::byte_t      delay_val;

    host_decoder u_decoder (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata), .req(req)
    );

    chip8_storage u_storage (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .req(req), .fetch_en(fetch_en),
        .fetch_addr_a(fetch_addr_a), .fetch_addr_b(fetch_addr_b),
        .mem_q_a(mem_q_a), .mem_q_b(mem_q_b), .vreg_q(vreg_q),
        .index_q(index_q), .pixel_q(pixel_q)
    );

    fetch_sequencer u_fetch (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .req(req),
        .mem_q_a(mem_q_a), .mem_q_b(mem_q_b), .fetch_en(fetch_en),
        .fetch_addr_a(fetch_addr_a), .fetch_addr_b(fetch_addr_b),
        .pc(pc), .state(state), .instr(instr)
    );

    timer_bank u_timers (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .req(req),
        .sound_val(sound_val), .delay_val(delay_val), .sound_on(sound_on)
    );

    readback_mux u_readback (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .req(req),
        .mem_q_a(mem_q_a), .vreg_q(vreg_q), .index_q(index_q), .pixel_q(pixel_q),
        .sound_val(sound_val), .delay_val(delay_val), .pc(pc), .state(state),
        .instr(instr), .data_out(data_out)
    );

endmodule

// ==== testbench/tb_chip8_checks.svh ====
//################################################
// Bus access tasks, random source and typed result checks
// Included inside the testbench top module body
//################################################
`ifndef TB_CHIP8_CHECKS_SVH
`define TB_CHIP8_CHECKS_SVH

    // One write, chipselect held for a single cycle
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        write      = 1'b0;
    endtask

    // Result sits on data_out after the third edge past the sampling edge
    task automatic bus_read(input bus_addr_t addr, input bus_data_t data,
                            output bus_data_t result);
        chipselect = 1'b1;
        write      = 1'b0;
        address    = addr;
        writedata  = data;
        @(posedge clk);
        #1;
        chipselect = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        result = data_out;
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string what, input bus_data_t got,
                                   input bus_data_t exp);
        errors++;
        $display("ERROR at %0t ns: %s returned 0x%0h, expected 0x%0h", $time, what, got, exp);
    endtask

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    // Upper bound only, for a value that may count down
    task automatic check_byte_at_most(input string what, input byte_t got, input byte_t lim);
        checks++;
        if ($isunknown(got) || got > lim) begin
            report_mismatch(what, bus_data_t'(got), bus_data_t'(lim));
        end
    endtask

    // Value inside a closed window, for a timer read shortly after its load
    task automatic check_byte_range(input string what, input byte_t got, input byte_t lo,
                                    input byte_t hi);
        checks++;
        if ($isunknown(got) || got < lo || got > hi) begin
            errors++;
            $display("ERROR at %0t ns: %s returned 0x%0h, expected 0x%0h to 0x%0h",
                     $time, what, got, lo, hi);
        end
    endtask

    task automatic check_index(input string what, input index_t got, input index_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_addr(input string what, input mem_addr_t got, input mem_addr_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_state(input string what, input emu_state_t got, input emu_state_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_instr(input string what, input instr_t got, input instr_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_pixel(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_mismatch(what, bus_data_t'(got), bus_data_t'(exp));
    endtask

    task automatic check_word(input string what, input bus_data_t got, input bus_data_t exp);
        checks++;
        if (got !== exp) report_mismatch(what, got, exp);
    endtask

`endif

// ==== testbench/tb_chip8_top.sv ====
//################################################
// Testbench for the CHIP-8 control core
// Builds a stimulus table, applies it over the host bus and checks results
//################################################
`timescale 1ns/1ps
`include "chip8_config.svh"

module tb_chip8_top;
    import chip8_core_pkg::*;
    import chip8_bus_pkg::*;

    typedef enum {op_write, op_read, op_idle, op_level, op_timer} row_op_t;
    typedef enum {
        k_none, k_byte, k_byte_tick, k_index, k_addr, k_state, k_instr, k_pixel, k_word
    } row_kind_t;

    typedef struct {
        row_op_t   op;
        bus_addr_t addr;
        bus_data_t data;
        row_kind_t kind;
        bus_data_t exp;
    } row_t;

    localparam mem_addr_t prog_start = 12'h300;
    localparam int        run_steps  = 3;
    localparam byte_t     sound_load = 8'd5;
    localparam byte_t     delay_load = 8'd40;

    logic        clk = 1'b0;
    logic        cpu_fbreset;
    logic        chipselect;
    logic        write;
    bus_addr_t   address;
    bus_data_t   writedata;
    bus_data_t   data_out;
    logic        sound_on;

    row_t        rows [$];
    int          errors = 0;
    int          checks = 0;
    int          timeout_cycles = 0;
    int          cycle_count = 0;
    logic [31:0] lcg_state = 32'h655b_8791;

    `include "tb_chip8_checks.svh"

    chip8_top dut0 (
        .clk(clk), .cpu_fbreset(cpu_fbreset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata), .data_out(data_out), .sound_on(sound_on)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic void add_row(row_op_t op, bus_addr_t addr, bus_data_t data,
                                    row_kind_t kind, bus_data_t exp);
        rows.push_back('{op, addr, data, kind, exp});
    endfunction

    // Bit 16 selects program memory
    function automatic bus_addr_t mem_bus_addr(input mem_addr_t a);
        return {1'b0, 1'b1, 4'b0, a};
    endfunction

    // y in 4:0, x in 13:8, value in bit 16
    function automatic bus_data_t pixel_word(input pix_x_t x, input pix_y_t y, input logic v);
        return {15'b0, v, 2'b0, x, 3'b0, y};
    endfunction

    task automatic build_table();
        byte_t     mem_model [int];
        mem_addr_t picks [$];
        mem_addr_t a;
        byte_t     b;
        bus_data_t w;
        instr_t    last_instr;
        int        pix_xs [6] = '{63, 0, 20, 20, 63, 0};
        int        pix_ys [6] = '{31, 0, 9, 9, 0, 31};
        logic      pix_vs [6] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
        // Reset values, then pc and state writes
        add_row(op_read, addr_pc, '0, k_addr, `CHIP8_PC_RESET);
        add_row(op_read, addr_state, '0, k_state, st_paused);
        add_row(op_read, addr_index, '0, k_index, '0);
        add_row(op_level, '0, '0, k_none, '0);
        add_row(op_write, addr_pc, 32'h2a4, k_none, '0);
        add_row(op_read, addr_pc, '0, k_addr, 32'h2a4);
        add_row(op_write, addr_state, st_loading_rom, k_none, '0);
        add_row(op_read, addr_state, '0, k_state, st_loading_rom);
        add_row(op_write, addr_state, st_paused, k_none, '0);
        // Burst of memory writes, one rewrite, then readback in reverse
        for (int i = 0; i < 12; i++) begin
            a = mem_addr_t'(lcg_next() >> 8);
            b = byte_t'(lcg_next() >> 16);
            mem_model[a] = b;
            picks.push_back(a);
            add_row(op_write, mem_bus_addr(a), b, k_none, '0);
        end
        add_row(op_read, mem_bus_addr(a), '0, k_byte, b);
        a = picks[2];
        b = byte_t'(lcg_next() >> 24);
        mem_model[a] = b;
        add_row(op_write, mem_bus_addr(a), b, k_none, '0);
        for (int i = picks.size() - 1; i >= 0; i--) begin
            add_row(op_read, mem_bus_addr(picks[i]), '0, k_byte, mem_model[picks[i]]);
        end
        for (int r = 0; r < 16; r++) begin
            b = byte_t'(lcg_next() >> 24);
            add_row(op_write, bus_addr_t'(r), b, k_none, '0);
            add_row(op_read, bus_addr_t'(r), '0, k_byte, b);
        end
        w = lcg_next() & 32'h0000_ffff;
        add_row(op_write, addr_index, w, k_none, '0);
        add_row(op_read, addr_index, '0, k_index, w);
        // 0x13 is a hole in the map
        add_row(op_write, 18'h13, 32'hffff_ffff, k_none, '0);
        add_row(op_read, 18'h13, '0, k_word, '0);
        for (int i = 0; i < 6; i++) begin
            w = pixel_word(pix_x_t'(pix_xs[i]), pix_y_t'(pix_ys[i]), pix_vs[i]);
            add_row(op_write, addr_pixel, w, k_none, '0);
            add_row(op_read, addr_pixel, w, k_pixel, bus_data_t'(pix_vs[i]));
        end
        add_row(op_read, addr_pixel, pixel_word(6'd63, 5'd31, 1'b0), k_pixel, 32'd1);
        add_row(op_read, addr_pixel, pixel_word(6'd0, 5'd0, 1'b0), k_pixel, 32'd1);
        add_row(op_read, addr_pixel, pixel_word(6'd20, 5'd9, 1'b0), k_pixel, 32'd0);
        // Short program, run for run_steps steps, then pause
        for (int i = 0; i < 2 * (run_steps + 1); i++) begin
            b = byte_t'(lcg_next() >> 8);
            mem_model[int'(prog_start) + i] = b;
            add_row(op_write, mem_bus_addr(prog_start + mem_addr_t'(i)), b, k_none, '0);
        end
        last_instr = {mem_model[int'(prog_start) + 2 * (run_steps - 1)],
                      mem_model[int'(prog_start) + 2 * (run_steps - 1) + 1]};
        add_row(op_write, addr_pc, prog_start, k_none, '0);
        add_row(op_write, addr_state, st_running, k_none, '0);
        add_row(op_idle, '0, run_steps * `CHIP8_STEP_CYCLES, k_none, '0);
        add_row(op_write, addr_state, st_paused, k_none, '0);
        add_row(op_read, addr_pc, '0, k_addr, bus_data_t'(prog_start) + 2 * run_steps);
        add_row(op_read, addr_instr, '0, k_instr, last_instr);
        add_row(op_read, addr_state, '0, k_state, st_paused);
        add_row(op_timer, addr_sound, sound_load, k_none, '0);
        // Read follows the load by one cycle so at most one tick has passed
        add_row(op_write, addr_delay, delay_load, k_none, '0);
        add_row(op_read, addr_delay, '0, k_byte_tick, delay_load);
    endtask

    task automatic compare_row(input row_t r, input bus_data_t got);
        string what;
        what = $sformatf("read of 0x%05h", r.addr);
        case (r.kind)
            k_byte:      check_byte(what, byte_t'(got), byte_t'(r.exp));
            k_byte_tick: check_byte_range(what, byte_t'(got),
                                          byte_t'(r.exp) - byte_t'(1), byte_t'(r.exp));
            k_index:     check_index(what, index_t'(got), index_t'(r.exp));
            k_addr:      check_addr(what, mem_addr_t'(got), mem_addr_t'(r.exp));
            k_state:     check_state(what, emu_state_t'(got[1:0]), emu_state_t'(r.exp[1:0]));
            k_instr:     check_instr(what, instr_t'(got), instr_t'(r.exp));
            k_pixel:     check_pixel(what, got[0], r.exp[0]);
            default:     check_word(what, got, r.exp);
        endcase
    endtask

    task automatic check_sound_countdown(input byte_t v);
        bus_data_t got;
        byte_t     prev;
        int        start;
        int        limit;
        start = cycle_count;
        limit = (int'(v) + 1) * `CHIP8_TICK_DIV;
        prev  = v;
        bus_write(addr_sound, bus_data_t'(v));
        // Load lands two edges after the access leaves the bus
        repeat (2) @(posedge clk);
        #1;
        check_level("sound_on after load", sound_on, 1'b1);
        while (prev != '0 && cycle_count - start <= limit) begin
            bus_read(addr_sound, '0, got);
            check_byte_at_most("sound timer readback", byte_t'(got), prev);
            prev = byte_t'(got);
        end
        if (cycle_count - start > limit) begin
            errors++;
            $display("Sound timer loaded with %0d did not reach zero within %0d cycles",
                     v, limit);
        end
        check_level("sound_on after countdown", sound_on, 1'b0);
    endtask

    initial begin
        bus_data_t got;
        int        budget;
        cpu_fbreset = 1'b1;
        chipselect  = 1'b0;
        write       = 1'b0;
        address     = '0;
        writedata   = '0;
        build_table();
        budget = 5 * rows.size() + run_steps * `CHIP8_STEP_CYCLES
               + (int'(sound_load) + 1) * `CHIP8_TICK_DIV;
        timeout_cycles = 2 * budget + 5;
        repeat (5) @(posedge clk);
        #1;
        cpu_fbreset = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].op)
                op_write: bus_write(rows[i].addr, rows[i].data);
                op_read: begin
                    bus_read(rows[i].addr, rows[i].data, got);
                    compare_row(rows[i], got);
                end
                op_idle: begin
                    repeat (rows[i].data) begin
                        @(posedge clk);
                        #1;
                    end
                end
                op_level: check_level("sound_on", sound_on, rows[i].exp[0]);
                default:  check_sound_countdown(byte_t'(rows[i].data));
            endcase
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog, armed once the table length is known
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hw
+incdir+testbench
hw/chip8_core_pkg.sv
hw/chip8_bus_pkg.sv
hw/host_decoder.sv
hw/chip8_storage.sv
hw/fetch_sequencer.sv
hw/timer_bank.sv
hw/readback_mux.sv
hw/chip8_top.sv
testbench/tb_chip8_top.sv
